// File: common/slot_cache_pkg.sv
package slot_cache_pkg;

    // Datapath widths
    localparam int unsigned NUM_LANES = 2;
    localparam int unsigned MAX_W     = 8;
    localparam int unsigned DEN_W     = 16;
    localparam int unsigned ID_W      = 6;

    // One lane of softmax state
    typedef struct packed {
        logic [MAX_W-1:0] maximum;
        logic [DEN_W-1:0] denominator;
    } lane_t;

    // Per-slot payload, also the backing memory word
    typedef lane_t [NUM_LANES-1:0] slot_data_t;

    typedef enum logic {
        ALLOC,
        LOAD
    } req_op_e;

    typedef enum logic {
        UPDATE,
        FREE
    } upd_op_e;

    // Slot modification selected by the controller
    typedef enum logic [2:0] {
        KIND_ACQUIRE,
        KIND_FILL,
        KIND_UPDATE,
        KIND_FREE,
        KIND_HIT
    } slot_kind_e;

    typedef struct packed {
        req_op_e         op;
        logic [ID_W-1:0] id;
    } slot_req_t;

    typedef struct packed {
        upd_op_e         op;
        logic [ID_W-1:0] id;
        slot_data_t      data;
    } slot_upd_t;

    // Spill write to the backing memory
    typedef struct packed {
        logic [ID_W-1:0] id;
        slot_data_t      data;
    } mem_wr_t;

endpackage

// File: design/op_fifo.sv
`timescale 1ns/1ps

module op_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 2
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic [WIDTH-1:0] push_data_i,
    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output logic [WIDTH-1:0] pop_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // A push refused while full stays offered until it is taken
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i));

endmodule

// File: slot_cache/slot_array.sv
`timescale 1ns/1ps

module slot_array #(
    parameter int unsigned N_SLOTS = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic [slot_cache_pkg::ID_W-1:0]        match_id_i,
    input  logic [slot_cache_pkg::ID_W-1:0]        lookup_id_i,
    input  logic                                   we_i,
    input  slot_cache_pkg::slot_kind_e             kind_i,
    input  logic [slot_cache_pkg::ID_W-1:0]        new_id_i,
    input  slot_cache_pkg::slot_data_t             upd_data_i,
    input  slot_cache_pkg::slot_data_t             fill_data_i,
    output logic                                   hit_o,
    output logic                                   free_o,
    output logic                                   lookup_hit_o,
    output slot_cache_pkg::slot_data_t             lookup_data_o,
    output slot_cache_pkg::mem_wr_t                victim_o
);

    import slot_cache_pkg::*;

    localparam int unsigned IDX_W = $clog2(N_SLOTS);
    localparam int unsigned USE_W = 4;

    slot_data_t       data_q  [N_SLOTS];
    logic [USE_W-1:0] uses_q  [N_SLOTS];
    logic [ID_W-1:0]  id_q    [N_SLOTS];
    logic             valid_q [N_SLOTS];

    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] zero_idx;
    logic [IDX_W-1:0] tgt_idx;
    logic             zero_found;

    // Match, free and zero-use searches; the lowest index wins
    always_comb begin
        hit_o        = 1'b0;
        free_o       = 1'b0;
        zero_found   = 1'b0;
        lookup_hit_o = 1'b0;
        hit_idx      = '0;
        free_idx     = '0;
        zero_idx     = '0;
        lookup_data_o = data_q[0];
        for (int i = N_SLOTS - 1; i >= 0; i--) begin
            if (valid_q[i] && id_q[i] == match_id_i) begin
                hit_o   = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_o   = 1'b1;
                free_idx = IDX_W'(i);
            end
            if (uses_q[i] == '0) begin
                zero_found = 1'b1;
                zero_idx   = IDX_W'(i);
            end
            if (valid_q[i] && id_q[i] == lookup_id_i) begin
                lookup_hit_o  = 1'b1;
                lookup_data_o = data_q[i];
            end
        end
    end

    assign tgt_idx = hit_o ? hit_idx : (free_o ? free_idx : zero_idx);

    // Slot that a spill writes back
    assign victim_o.id   = id_q[zero_idx];
    assign victim_o.data = data_q[zero_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < N_SLOTS; i++) begin
                uses_q[i]  <= '0;
                id_q[i]    <= '0;
                valid_q[i] <= 1'b0;
            end
        end else if (we_i) begin
            case (kind_i)
                KIND_ACQUIRE, KIND_FILL: begin
                    uses_q[tgt_idx]  <= USE_W'(1);
                    id_q[tgt_idx]    <= new_id_i;
                    valid_q[tgt_idx] <= 1'b1;
                end
                KIND_UPDATE: uses_q[tgt_idx] <= uses_q[tgt_idx] - 1'b1;
                KIND_FREE: begin
                    uses_q[tgt_idx]  <= '0;
                    valid_q[tgt_idx] <= 1'b0;
                end
                default: uses_q[tgt_idx] <= uses_q[tgt_idx] + 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            case (kind_i)
                KIND_ACQUIRE: data_q[tgt_idx] <= '0;
                KIND_FILL:    data_q[tgt_idx] <= fill_data_i;
                KIND_UPDATE:  data_q[tgt_idx] <= upd_data_i;
                default:      data_q[tgt_idx] <= data_q[tgt_idx];
            endcase
        end
    end

    // A write with nowhere to go means the controller evicted a busy slot
    a_target_exists: assert property (@(posedge clk_i) disable iff (!rst_ni)
        we_i |-> (hit_o || free_o || zero_found));

endmodule

// File: slot_cache/slot_cache_ctrl.sv
`timescale 1ns/1ps

module slot_cache_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                req_valid_i,
    input  slot_cache_pkg::slot_req_t           req_i,
    input  logic                                upd_valid_i,
    input  slot_cache_pkg::slot_upd_t           upd_i,
    input  logic                                hit_i,
    input  logic                                free_i,
    input  logic                                mem_wr_ready_i,
    input  logic                                mem_rd_ready_i,
    input  logic                                mem_rd_rsp_valid_i,
    output logic                                req_pop_o,
    output logic                                upd_pop_o,
    output logic [slot_cache_pkg::ID_W-1:0]     match_id_o,
    output logic                                we_o,
    output slot_cache_pkg::slot_kind_e          kind_o,
    output logic                                mem_wr_valid_o,
    output logic                                mem_rd_valid_o
);

    import slot_cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_STORE,
        WAIT_LOAD,
        FINISHED
    } state_e;

    state_e state_q, state_d;
    logic   rd_sent_q, rd_sent_d;

    always_comb begin
        state_d        = state_q;
        rd_sent_d      = rd_sent_q;
        req_pop_o      = 1'b0;
        upd_pop_o      = 1'b0;
        we_o           = 1'b0;
        kind_o         = KIND_HIT;
        mem_wr_valid_o = 1'b0;
        mem_rd_valid_o = 1'b0;
        // Request ID stays on the match port while data moves
        match_id_o     = req_i.id;

        case (state_q)
            IDLE: begin
                if (upd_valid_i) begin
                    // Updates go first
                    match_id_o = upd_i.id;
                    we_o       = 1'b1;
                    kind_o     = (upd_i.op == UPDATE) ? KIND_UPDATE : KIND_FREE;
                    upd_pop_o  = 1'b1;
                end else if (req_valid_i) begin
                    if (hit_i) begin
                        we_o      = 1'b1;
                        req_pop_o = 1'b1;
                    end else if (free_i) begin
                        if (req_i.op == LOAD) begin
                            state_d = WAIT_LOAD;
                        end else begin
                            we_o      = 1'b1;
                            kind_o    = KIND_ACQUIRE;
                            req_pop_o = 1'b1;
                        end
                    end else begin
                        state_d = WAIT_STORE;
                    end
                end
            end
            WAIT_STORE: begin
                mem_wr_valid_o = 1'b1;
                if (mem_wr_ready_i) begin
                    if (req_i.op == ALLOC) begin
                        we_o      = 1'b1;
                        kind_o    = KIND_ACQUIRE;
                        req_pop_o = 1'b1;
                        state_d   = FINISHED;
                    end else begin
                        state_d = WAIT_LOAD;
                    end
                end
            end
            WAIT_LOAD: begin
                mem_rd_valid_o = !rd_sent_q;
                if (mem_rd_valid_o && mem_rd_ready_i) begin
                    rd_sent_d = 1'b1;
                end
                // Response only counts once the read was accepted
                if (rd_sent_q && mem_rd_rsp_valid_i) begin
                    we_o      = 1'b1;
                    kind_o    = KIND_FILL;
                    req_pop_o = 1'b1;
                    rd_sent_d = 1'b0;
                    state_d   = FINISHED;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            rd_sent_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_sent_q <= rd_sent_d;
        end
    end

    // A waiting spill keeps its valid and the request that selected the victim
    a_wr_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_wr_valid_o && !mem_wr_ready_i |=> mem_wr_valid_o && $stable(match_id_o));

endmodule

// File: slot_cache/slot_cache_top.sv
`timescale 1ns/1ps

module slot_cache_top #(
    parameter int unsigned N_SLOTS   = 4,
    parameter int unsigned REQ_DEPTH = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  slot_cache_pkg::slot_req_t           req_i,
    input  logic                                upd_valid_i,
    output logic                                upd_ready_o,
    input  slot_cache_pkg::slot_upd_t           upd_i,
    input  logic [slot_cache_pkg::ID_W-1:0]     lookup_id_i,
    output logic                                lookup_valid_o,
    output slot_cache_pkg::slot_data_t          lookup_data_o,
    output logic                                mem_wr_valid_o,
    input  logic                                mem_wr_ready_i,
    output slot_cache_pkg::mem_wr_t             mem_wr_o,
    output logic                                mem_rd_valid_o,
    input  logic                                mem_rd_ready_i,
    output logic [slot_cache_pkg::ID_W-1:0]     mem_rd_id_o,
    input  logic                                mem_rd_rsp_valid_i,
    input  slot_cache_pkg::slot_data_t          mem_rd_rsp_i
);

    import slot_cache_pkg::*;

    localparam int unsigned UPD_DEPTH = 2;

    slot_req_t       req_head;
    slot_upd_t       upd_head;
    logic            req_head_valid, upd_head_valid;
    logic            req_pop, upd_pop;
    logic            hit, free, we, lookup_hit;
    logic [ID_W-1:0] match_id;
    slot_kind_e      kind;

    op_fifo #(.WIDTH($bits(slot_req_t)), .DEPTH(REQ_DEPTH)) i_req_fifo (
        .clk_i, .rst_ni,
        .push_valid_i (req_valid_i),    .push_ready_o (req_ready_o),
        .push_data_i  (req_i),
        .pop_valid_o  (req_head_valid), .pop_ready_i  (req_pop),
        .pop_data_o   (req_head)
    );

    op_fifo #(.WIDTH($bits(slot_upd_t)), .DEPTH(UPD_DEPTH)) i_upd_fifo (
        .clk_i, .rst_ni,
        .push_valid_i (upd_valid_i),    .push_ready_o (upd_ready_o),
        .push_data_i  (upd_i),
        .pop_valid_o  (upd_head_valid), .pop_ready_i  (upd_pop),
        .pop_data_o   (upd_head)
    );

    slot_array #(.N_SLOTS(N_SLOTS)) i_slot_array (
        .clk_i, .rst_ni,
        .match_id_i   (match_id),        .lookup_id_i   (lookup_id_i),
        .we_i         (we),              .kind_i        (kind),
        .new_id_i     (req_head.id),     .upd_data_i    (upd_head.data),
        .fill_data_i  (mem_rd_rsp_i),
        .hit_o        (hit),             .free_o        (free),
        .lookup_hit_o (lookup_hit),      .lookup_data_o (lookup_data_o),
        .victim_o     (mem_wr_o)
    );

    slot_cache_ctrl i_ctrl (
        .clk_i, .rst_ni,
        .req_valid_i    (req_head_valid), .req_i          (req_head),
        .upd_valid_i    (upd_head_valid), .upd_i          (upd_head),
        .hit_i          (hit),            .free_i         (free),
        .mem_wr_ready_i, .mem_rd_ready_i, .mem_rd_rsp_valid_i,
        .req_pop_o      (req_pop),        .upd_pop_o      (upd_pop),
        .match_id_o     (match_id),       .we_o           (we),
        .kind_o         (kind),
        .mem_wr_valid_o, .mem_rd_valid_o
    );

    assign mem_rd_id_o = req_head.id;

    // Hide a slot whose pending update has not been applied yet
    assign lookup_valid_o = lookup_hit && !(upd_head_valid && upd_head.id == lookup_id_i);

endmodule

// File: testbench/tb_slot_cache.sv
`timescale 1ns/1ps

module tb_slot_cache;

    import slot_cache_pkg::*;

    localparam int unsigned N_SLOTS    = 4;
    localparam int          FIRST_IDS  = 6;
    localparam int          ROUNDS     = 24;
    localparam int          MAX_CYCLES = 2000;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic            req_valid_i;
    logic            req_ready_o;
    slot_req_t       req_i;
    logic            upd_valid_i;
    logic            upd_ready_o;
    slot_upd_t       upd_i;
    logic [ID_W-1:0] lookup_id_i;
    logic            lookup_valid_o;
    slot_data_t      lookup_data_o;
    logic            mem_wr_valid_o;
    logic            mem_wr_ready_i = 1'b0;
    mem_wr_t         mem_wr_o;
    logic            mem_rd_valid_o;
    logic            mem_rd_ready_i = 1'b0;
    logic [ID_W-1:0] mem_rd_id_o;
    logic            mem_rd_rsp_valid_i = 1'b0;
    slot_data_t      mem_rd_rsp_i = '0;

    // Expected contents per ID and the backing memory
    slot_data_t      ref_data  [2**ID_W];
    logic            known     [2**ID_W];
    slot_data_t      mem_model [logic [ID_W-1:0]];

    integer          seed = 6;
    int              cycles;
    int              spill_count;
    int              fill_count;
    int              wr_wait = -1;
    int              rd_wait = -1;
    int              rsp_wait;
    logic [ID_W-1:0] rd_id;
    int              err_lookup;
    int              err_mem;
    int              err_flow;

    slot_cache_top #(.N_SLOTS(N_SLOTS), .REQ_DEPTH(4)) i_dut (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        err_flow++;
        $display("%0t: %s", $time, what);
    endtask

    // Backing memory with random ready delays and a fixed fill latency
    always @(posedge clk_i) begin
        mem_rd_rsp_valid_i <= 1'b0;
        if (!rst_ni) begin
            mem_wr_ready_i <= 1'b0;
            mem_rd_ready_i <= 1'b0;
        end else begin
            if (mem_wr_valid_o && mem_wr_ready_i) begin
                assert (known[mem_wr_o.id] && mem_wr_o.data == ref_data[mem_wr_o.id]) else begin
                    err_mem++;
                    report_value("mem_wr_o.data", 64'(mem_wr_o.data),
                                 64'(ref_data[mem_wr_o.id]));
                end
                mem_model[mem_wr_o.id] = mem_wr_o.data;
                spill_count++;
                mem_wr_ready_i <= 1'b0;
                wr_wait = -1;
            end else if (mem_wr_valid_o) begin
                if (wr_wait < 0) begin
                    wr_wait = $unsigned($random(seed)) % 4;
                end
                if (wr_wait == 0) begin
                    mem_wr_ready_i <= 1'b1;
                end else begin
                    wr_wait--;
                end
            end
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rd_rsp_valid_i <= 1'b1;
                    mem_rd_rsp_i <= mem_model.exists(rd_id) ? mem_model[rd_id] : '0;
                end
            end
            if (mem_rd_valid_o && mem_rd_ready_i) begin
                assert (mem_model.exists(mem_rd_id_o)) else begin
                    err_mem++;
                    $display("%0t: fill requested for ID %0d, never spilled", $time, mem_rd_id_o);
                end
                rd_id = mem_rd_id_o;
                fill_count++;
                rsp_wait = 2;
                mem_rd_ready_i <= 1'b0;
                rd_wait = -1;
            end else if (mem_rd_valid_o) begin
                if (rd_wait < 0) begin
                    rd_wait = $unsigned($random(seed)) % 4;
                end
                if (rd_wait == 0) begin
                    mem_rd_ready_i <= 1'b1;
                end else begin
                    rd_wait--;
                end
            end
        end
    end

    // Any valid lookup must show the latest data of an allocated ID
    always @(negedge clk_i) begin
        if (rst_ni && lookup_valid_o) begin
            assert (known[lookup_id_i]) else begin
                err_lookup++;
                $display("%0t: lookup of free ID %0d is valid", $time, lookup_id_i);
            end
            if (known[lookup_id_i]) begin
                assert (lookup_data_o == ref_data[lookup_id_i]) else begin
                    err_lookup++;
                    report_value("lookup_data_o", 64'(lookup_data_o),
                                 64'(ref_data[lookup_id_i]));
                end
            end
        end
    end

    function automatic slot_data_t random_data();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[$bits(slot_data_t)-1:0];
    endfunction

    task automatic point_lookup(input logic [ID_W-1:0] id);
        @(posedge clk_i);
        lookup_id_i <= id;
    endtask

    task automatic send_req(input req_op_e op, input logic [ID_W-1:0] id);
        slot_req_t item;
        item.op = op;
        item.id = id;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= item;
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic send_upd(input upd_op_e op, input logic [ID_W-1:0] id,
                            input slot_data_t data);
        slot_upd_t item;
        item.op   = op;
        item.id   = id;
        item.data = data;
        @(posedge clk_i);
        upd_valid_i <= 1'b1;
        upd_i       <= item;
        @(posedge clk_i);
        while (!upd_ready_o) @(posedge clk_i);
        upd_valid_i <= 1'b0;
    endtask

    task automatic wait_req_done();
        @(negedge clk_i);
        while (i_dut.req_head_valid) @(negedge clk_i);
    endtask

    // Lookup of the queued ID stays invalid until the update is popped
    task automatic wait_upd_applied(input logic [ID_W-1:0] id);
        @(negedge clk_i);
        while (i_dut.upd_head_valid) begin
            assert (!lookup_valid_o)
                else note_failure($sformatf("lookup of ID %0d valid while update queued", id));
            @(negedge clk_i);
        end
    endtask

    task automatic check_visible(input logic [ID_W-1:0] id);
        assert (lookup_valid_o)
            else note_failure($sformatf("ID %0d not on lookup after its request", id));
    endtask

    task automatic alloc_id(input logic [ID_W-1:0] id);
        point_lookup(id);
        send_req(ALLOC, id);
        known[id]    = 1'b1;
        ref_data[id] = '0;
        wait_req_done();
        check_visible(id);
    endtask

    task automatic update_id(input logic [ID_W-1:0] id, input slot_data_t data);
        point_lookup(id);
        send_upd(UPDATE, id, data);
        ref_data[id] = data;
        wait_upd_applied(id);
        check_visible(id);
    endtask

    task automatic free_id(input logic [ID_W-1:0] id);
        point_lookup(id);
        send_upd(FREE, id, '0);
        known[id] = 1'b0;
        wait_upd_applied(id);
        assert (!lookup_valid_o)
            else note_failure($sformatf("lookup of ID %0d still valid after FREE", id));
    endtask

    task automatic load_id(input logic [ID_W-1:0] id);
        logic on_chip;
        int   fills_before;
        point_lookup(id);
        @(negedge clk_i);
        on_chip      = lookup_valid_o;
        fills_before = fill_count;
        send_req(LOAD, id);
        wait_req_done();
        check_visible(id);
        if (on_chip) begin
            assert (fill_count == fills_before)
                else note_failure($sformatf("LOAD of on-chip ID %0d caused a fill", id));
        end else begin
            assert (fill_count == fills_before + 1 && rd_id == id)
                else note_failure($sformatf("LOAD of spilled ID %0d sent no fill for it", id));
            assert (lookup_data_o == mem_model[id]) else begin
                err_mem++;
                report_value("lookup_data_o", 64'(lookup_data_o), 64'(mem_model[id]));
            end
        end
    endtask

    // Lowest known ID among the first ones that is on chip or spilled
    task automatic find_id(input logic want_on_chip, output logic [ID_W-1:0] found);
        found = '0;
        for (int id = 1; id <= FIRST_IDS; id++) begin
            point_lookup(ID_W'(id));
            @(negedge clk_i);
            if (known[id] && lookup_valid_o == want_on_chip && found == '0) begin
                found = ID_W'(id);
            end
        end
    endtask

    initial begin
        logic [ID_W-1:0] pick;
        int              spills_before;
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        upd_valid_i = 1'b0;
        upd_i       = '0;
        lookup_id_i = '0;
        foreach (known[i]) begin
            known[i] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (!mem_wr_valid_o && !mem_rd_valid_o && !lookup_valid_o
                && req_ready_o && upd_ready_o)
            else note_failure("outputs not in their reset state");

        // More IDs than slots, so the last ones force spills
        for (int id = 1; id <= FIRST_IDS; id++) begin
            alloc_id(ID_W'(id));
            update_id(ID_W'(id), random_data());
        end
        assert (spill_count == FIRST_IDS - N_SLOTS)
            else note_failure($sformatf("%0d spills seen after filling the slots", spill_count));

        find_id(1'b0, pick);
        if (pick == '0) begin
            note_failure("no spilled ID found for the fill test");
        end else begin
            load_id(pick);
            update_id(pick, random_data());
        end

        find_id(1'b1, pick);
        free_id(pick);
        spills_before = spill_count;
        alloc_id(ID_W'(FIRST_IDS + 1));
        assert (spill_count == spills_before)
            else note_failure("ALLOC after FREE caused a spill");
        update_id(ID_W'(FIRST_IDS + 1), random_data());

        // Random mix of allocations, hits and fills
        for (int r = 0; r < ROUNDS; r++) begin
            pick = ID_W'(1 + $unsigned($random(seed)) % 12);
            if (known[pick]) begin
                load_id(pick);
            end else begin
                alloc_id(pick);
            end
            update_id(pick, random_data());
        end

        $display("Errors: lookup %0d, memory %0d, flow %0d", err_lookup, err_mem, err_flow);
        if (err_lookup + err_mem + err_flow == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
common/slot_cache_pkg.sv
design/op_fifo.sv
slot_cache/slot_array.sv
slot_cache/slot_cache_ctrl.sv
slot_cache/slot_cache_top.sv
testbench/tb_slot_cache.sv

// File: Makefile
# Verilator simulation of the slot cache testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_slot_cache -f compile.f -o Vtb_slot_cache
	./obj_dir/Vtb_slot_cache 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Test failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
